//--- design/soc_pkg.sv
package soc_pkg;

	// ======================================================================
	// Bus geometry
	// ======================================================================
	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;

	// RAM holds RAM_WORDS words, addressed through byte address bits above 1:0
	localparam int RAM_WORDS = 1024;
	localparam int RAM_AW = $clog2(RAM_WORDS);

	// ======================================================================
	// Address map
	// ======================================================================
	localparam logic [ADDR_W-1:0] RAM_BASE = 32'h0001_0000;
	localparam logic [ADDR_W-1:0] PERIPH_BASE = 32'h5000_0000;
	// Four 32-bit registers
	localparam int PERIPH_SIZE = 16;

	localparam int LED_W = 10;

	// Arbiter grant state
	typedef enum logic [1:0] {ARB_IDLE, ARB_PA, ARB_PB} arb_state_e;

	// Decoded target of the internal bus
	typedef enum logic [1:0] {TGT_RAM, TGT_PERIPH, TGT_NONE} bus_target_e;

	// Peripheral register select, byte address bits 3:2
	typedef enum logic [1:0] {
		REG_LED = 2'd0,
		REG_CYCLES = 2'd1,
		REG_PA_COUNT = 2'd2,
		REG_PB_COUNT = 2'd3
	} periph_reg_e;

endpackage

//--- design/bus_access.sv
`timescale 1ns/10ps

module bus_access (
	input  logic                       clock,
	input  logic                       i_rst,
	// Port A, instruction fetch, read only
	input  logic                       i_pa_cyc,
	input  logic                       i_pa_stb,
	input  logic [soc_pkg::ADDR_W-1:0] i_pa_adr,
	output logic [soc_pkg::DATA_W-1:0] o_pa_dat,
	output logic                       o_pa_ack,
	// Port B, data
	input  logic                       i_pb_cyc,
	input  logic                       i_pb_stb,
	input  logic                       i_pb_we,
	input  logic [soc_pkg::ADDR_W-1:0] i_pb_adr,
	input  logic [soc_pkg::DATA_W-1:0] i_pb_dat,
	output logic [soc_pkg::DATA_W-1:0] o_pb_dat,
	output logic                       o_pb_ack,
	// Internal bus master
	output logic                       o_m_cyc,
	output logic                       o_m_stb,
	output logic                       o_m_we,
	output logic [soc_pkg::ADDR_W-1:0] o_m_adr,
	output logic [soc_pkg::DATA_W-1:0] o_m_dat_w,
	input  logic [soc_pkg::DATA_W-1:0] i_m_dat_r,
	input  logic                       i_m_ack,
	output logic                       o_pa_done,
	output logic                       o_pb_done
);
	import soc_pkg::*;

	arb_state_e state_q;
	arb_state_e state_d;
	logic       last_b_q;
	logic       pa_req;
	logic       pb_req;

	assign pa_req = i_pa_cyc && i_pa_stb;
	assign pb_req = i_pb_cyc && i_pb_stb;

	// Round robin, B granted last means A goes first on a tie
	always_comb
	begin
		state_d = state_q;
		case (state_q)
			ARB_IDLE:
			begin
				if (pa_req && (!pb_req || last_b_q))
					state_d = ARB_PA;
				else if (pb_req)
					state_d = ARB_PB;
			end
			ARB_PA, ARB_PB:
			begin
				if (i_m_ack)
					state_d = ARB_IDLE;
			end
			default: state_d = ARB_IDLE;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (i_rst)
		begin
			state_q <= ARB_IDLE;
			last_b_q <= 1'b1;
		end
		else
		begin
			state_q <= state_d;
			if (state_q == ARB_IDLE && state_d == ARB_PA)
				last_b_q <= 1'b0;
			else if (state_q == ARB_IDLE && state_d == ARB_PB)
				last_b_q <= 1'b1;
		end
	end

	// Forward the granted request, ports hold it steady until ack
	assign o_m_cyc = (state_q == ARB_PA) ? i_pa_cyc : (state_q == ARB_PB) ? i_pb_cyc : 1'b0;
	assign o_m_stb = (state_q == ARB_PA) ? i_pa_stb : (state_q == ARB_PB) ? i_pb_stb : 1'b0;
	assign o_m_we = (state_q == ARB_PB) ? i_pb_we : 1'b0;
	assign o_m_adr = (state_q == ARB_PA) ? i_pa_adr : (state_q == ARB_PB) ? i_pb_adr : '0;
	assign o_m_dat_w = (state_q == ARB_PB) ? i_pb_dat : '0;

	// Return path goes to the granted port only
	assign o_pa_ack = (state_q == ARB_PA) && i_m_ack;
	assign o_pb_ack = (state_q == ARB_PB) && i_m_ack;
	assign o_pa_dat = (state_q == ARB_PA) ? i_m_dat_r : '0;
	assign o_pb_dat = (state_q == ARB_PB) ? i_m_dat_r : '0;
	assign o_pa_done = o_pa_ack;
	assign o_pb_done = o_pb_ack;

	a_no_ack_idle: assert property (@(posedge clock) disable iff (i_rst)
		state_q == ARB_IDLE |-> !i_m_ack);
	a_pa_ack_stb: assert property (@(posedge clock) disable iff (i_rst)
		o_pa_ack |-> i_pa_cyc && i_pa_stb);
	a_pb_ack_stb: assert property (@(posedge clock) disable iff (i_rst)
		o_pb_ack |-> i_pb_cyc && i_pb_stb);

endmodule

//--- design/ram_block.sv
`timescale 1ns/10ps

module ram_block (
	input  logic                       clock,
	input  logic                       i_rst,
	input  logic                       i_stb,
	input  logic                       i_we,
	input  logic [soc_pkg::RAM_AW-1:0] i_word_adr,
	input  logic [soc_pkg::DATA_W-1:0] i_dat,
	output logic [soc_pkg::DATA_W-1:0] o_dat,
	output logic                       o_ack
);
	import soc_pkg::*;

	logic [DATA_W-1:0] mem [RAM_WORDS];
	logic              first_cycle;

	// High only in the cycle stb first appears
	assign first_cycle = i_stb && !o_ack;

	// ======================================================================
	// Storage
	// ======================================================================
	always_ff @(posedge clock)
	begin
		if (first_cycle && i_we)
			mem[i_word_adr] <= i_dat;
	end

	// Read data lands together with ack
	always_ff @(posedge clock)
	begin
		if (first_cycle)
			o_dat <= mem[i_word_adr];
	end

	// ======================================================================
	// Handshake
	// ======================================================================
	always_ff @(posedge clock)
	begin
		if (i_rst)
			o_ack <= 1'b0;
		else
			o_ack <= first_cycle;
	end

	// A request stays up until its ack
	a_stb_held: assert property (@(posedge clock) disable iff (i_rst)
		i_stb && !o_ack |=> i_stb);

endmodule

//--- design/periph_block.sv
`timescale 1ns/10ps

module periph_block (
	input  logic                       clock,
	input  logic                       i_rst,
	input  logic                       i_stb,
	input  logic                       i_we,
	input  soc_pkg::periph_reg_e       i_reg,
	input  logic [soc_pkg::DATA_W-1:0] i_dat,
	output logic [soc_pkg::DATA_W-1:0] o_dat,
	output logic                       o_ack,
	input  logic                       i_pa_done,
	input  logic                       i_pb_done,
	output logic [soc_pkg::LED_W-1:0]  o_ledr
);
	import soc_pkg::*;

	logic [LED_W-1:0]  led_q;
	logic [31:0]       cycles_q;
	logic [31:0]       pa_count_q;
	logic [31:0]       pb_count_q;
	logic [DATA_W-1:0] rdata;
	logic              first_cycle;

	assign first_cycle = i_stb && !o_ack;

	// ======================================================================
	// Registers and counters
	// ======================================================================
	always_ff @(posedge clock)
	begin
		if (i_rst)
		begin
			led_q <= '0;
			cycles_q <= '0;
			pa_count_q <= '0;
			pb_count_q <= '0;
		end
		else
		begin
			cycles_q <= cycles_q + 32'd1;
			// Counts advance at the end of the ack cycle
			if (i_pa_done)
				pa_count_q <= pa_count_q + 32'd1;
			if (i_pb_done)
				pb_count_q <= pb_count_q + 32'd1;
			// Only the LED register accepts writes
			if (first_cycle && i_we && i_reg == REG_LED)
				led_q <= i_dat[LED_W-1:0];
		end
	end

	// Read mux
	always_comb
	begin
		case (i_reg)
			REG_LED:      rdata = DATA_W'(led_q);
			REG_CYCLES:   rdata = DATA_W'(cycles_q);
			REG_PA_COUNT: rdata = DATA_W'(pa_count_q);
			REG_PB_COUNT: rdata = DATA_W'(pb_count_q);
			default:      rdata = '0;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (first_cycle)
			o_dat <= rdata;
	end

	always_ff @(posedge clock)
	begin
		if (i_rst)
			o_ack <= 1'b0;
		else
			o_ack <= first_cycle;
	end

	assign o_ledr = led_q;

endmodule

//--- design/bus_fabric.sv
`timescale 1ns/10ps

module bus_fabric (
	input  logic                       clock,
	input  logic                       i_rst,
	input  logic                       i_m_cyc,
	input  logic                       i_m_stb,
	input  logic                       i_m_we,
	input  logic [soc_pkg::ADDR_W-1:0] i_m_adr,
	input  logic [soc_pkg::DATA_W-1:0] i_m_dat_w,
	output logic [soc_pkg::DATA_W-1:0] o_m_dat_r,
	output logic                       o_m_ack,
	output logic                       o_ram_stb,
	output logic                       o_ram_we,
	output logic [soc_pkg::RAM_AW-1:0] o_ram_word_adr,
	output logic [soc_pkg::DATA_W-1:0] o_ram_dat,
	input  logic [soc_pkg::DATA_W-1:0] i_ram_dat,
	input  logic                       i_ram_ack,
	output logic                       o_per_stb,
	output logic                       o_per_we,
	output soc_pkg::periph_reg_e       o_per_reg,
	output logic [soc_pkg::DATA_W-1:0] o_per_dat,
	input  logic [soc_pkg::DATA_W-1:0] i_per_dat,
	input  logic                       i_per_ack
);
	import soc_pkg::*;

	localparam logic [ADDR_W-1:0] RAM_TOP = RAM_BASE + ADDR_W'(RAM_WORDS * 4);
	localparam logic [ADDR_W-1:0] PERIPH_TOP = PERIPH_BASE + ADDR_W'(PERIPH_SIZE);

	bus_target_e target;
	logic        req;
	logic        none_ack_q;

	assign req = i_m_cyc && i_m_stb;

	// ======================================================================
	// Address decode
	// ======================================================================
	always_comb
	begin
		if (i_m_adr >= RAM_BASE && i_m_adr < RAM_TOP)
			target = TGT_RAM;
		else if (i_m_adr >= PERIPH_BASE && i_m_adr < PERIPH_TOP)
			target = TGT_PERIPH;
		else
			target = TGT_NONE;
	end

	assign o_ram_stb = req && target == TGT_RAM;
	assign o_ram_we = i_m_we;
	assign o_ram_word_adr = i_m_adr[2 +: RAM_AW];
	assign o_ram_dat = i_m_dat_w;

	assign o_per_stb = req && target == TGT_PERIPH;
	assign o_per_we = i_m_we;
	assign o_per_reg = periph_reg_e'(i_m_adr[3:2]);
	assign o_per_dat = i_m_dat_w;

	// Unmapped accesses complete with zero data one cycle later
	always_ff @(posedge clock)
	begin
		if (i_rst)
			none_ack_q <= 1'b0;
		else
			none_ack_q <= req && target == TGT_NONE && !none_ack_q;
	end

	assign o_m_ack = (target == TGT_RAM) ? i_ram_ack :
		(target == TGT_PERIPH) ? i_per_ack : none_ack_q;
	assign o_m_dat_r = (target == TGT_RAM) ? i_ram_dat :
		(target == TGT_PERIPH) ? i_per_dat : '0;

	// Acks come back only while the master still requests
	a_ack_with_req: assert property (@(posedge clock) disable iff (i_rst)
		o_m_ack |-> i_m_cyc && i_m_stb);

endmodule

//--- design/soc_core.sv
`timescale 1ns/10ps

module soc_core (
	input  logic                       clock,
	input  logic                       i_rst,
	// Port A, instruction
	input  logic                       i_pa_cyc,
	input  logic                       i_pa_stb,
	input  logic [soc_pkg::ADDR_W-1:0] i_pa_adr,
	output logic [soc_pkg::DATA_W-1:0] o_pa_dat,
	output logic                       o_pa_ack,
	// Port B, data
	input  logic                       i_pb_cyc,
	input  logic                       i_pb_stb,
	input  logic                       i_pb_we,
	input  logic [soc_pkg::ADDR_W-1:0] i_pb_adr,
	input  logic [soc_pkg::DATA_W-1:0] i_pb_dat,
	output logic [soc_pkg::DATA_W-1:0] o_pb_dat,
	output logic                       o_pb_ack,
	output logic [soc_pkg::LED_W-1:0]  o_ledr
);
	import soc_pkg::*;

	// ======================================================================
	// Internal bus
	// ======================================================================
	logic              m_cyc;
	logic              m_stb;
	logic              m_we;
	logic [ADDR_W-1:0] m_adr;
	logic [DATA_W-1:0] m_dat_w;
	logic [DATA_W-1:0] m_dat_r;
	logic              m_ack;
	logic              pa_done;
	logic              pb_done;

	// RAM side
	logic              ram_stb;
	logic              ram_we;
	logic [RAM_AW-1:0] ram_word_adr;
	logic [DATA_W-1:0] ram_dat_w;
	logic [DATA_W-1:0] ram_dat_r;
	logic              ram_ack;

	// Peripheral side
	logic              per_stb;
	logic              per_we;
	periph_reg_e       per_reg;
	logic [DATA_W-1:0] per_dat_w;
	logic [DATA_W-1:0] per_dat_r;
	logic              per_ack;

	bus_access u_bus_access (
		.clock(clock), .i_rst(i_rst),
		.i_pa_cyc(i_pa_cyc), .i_pa_stb(i_pa_stb), .i_pa_adr(i_pa_adr),
		.o_pa_dat(o_pa_dat), .o_pa_ack(o_pa_ack),
		.i_pb_cyc(i_pb_cyc), .i_pb_stb(i_pb_stb), .i_pb_we(i_pb_we),
		.i_pb_adr(i_pb_adr), .i_pb_dat(i_pb_dat),
		.o_pb_dat(o_pb_dat), .o_pb_ack(o_pb_ack),
		.o_m_cyc(m_cyc), .o_m_stb(m_stb), .o_m_we(m_we), .o_m_adr(m_adr),
		.o_m_dat_w(m_dat_w), .i_m_dat_r(m_dat_r), .i_m_ack(m_ack),
		.o_pa_done(pa_done), .o_pb_done(pb_done)
	);

	bus_fabric u_bus_fabric (
		.clock(clock), .i_rst(i_rst),
		.i_m_cyc(m_cyc), .i_m_stb(m_stb), .i_m_we(m_we), .i_m_adr(m_adr),
		.i_m_dat_w(m_dat_w), .o_m_dat_r(m_dat_r), .o_m_ack(m_ack),
		.o_ram_stb(ram_stb), .o_ram_we(ram_we), .o_ram_word_adr(ram_word_adr),
		.o_ram_dat(ram_dat_w), .i_ram_dat(ram_dat_r), .i_ram_ack(ram_ack),
		.o_per_stb(per_stb), .o_per_we(per_we), .o_per_reg(per_reg),
		.o_per_dat(per_dat_w), .i_per_dat(per_dat_r), .i_per_ack(per_ack)
	);

	ram_block u_ram_block (
		.clock(clock), .i_rst(i_rst),
		.i_stb(ram_stb), .i_we(ram_we), .i_word_adr(ram_word_adr),
		.i_dat(ram_dat_w), .o_dat(ram_dat_r), .o_ack(ram_ack)
	);

	periph_block u_periph_block (
		.clock(clock), .i_rst(i_rst),
		.i_stb(per_stb), .i_we(per_we), .i_reg(per_reg),
		.i_dat(per_dat_w), .o_dat(per_dat_r), .o_ack(per_ack),
		.i_pa_done(pa_done), .i_pb_done(pb_done), .o_ledr(o_ledr)
	);

endmodule

//--- include/soc_tb_table.svh
`ifndef SOC_TB_TABLE_SVH
`define SOC_TB_TABLE_SVH

// Register addresses inside the peripheral window
localparam logic [31:0] LED_ADR = PERIPH_BASE;
localparam logic [31:0] CYC_ADR = PERIPH_BASE + 32'h4;
localparam logic [31:0] PA_CNT_ADR = PERIPH_BASE + 32'h8;
localparam logic [31:0] PB_CNT_ADR = PERIPH_BASE + 32'hC;

localparam logic PORT_A = 1'b0;
localparam logic PORT_B = 1'b1;

// Columns: port, write flag, byte address, write data, expected read data
typedef struct packed {
	logic        port;
	logic        is_write;
	logic [31:0] adr;
	logic [31:0] wdat;
	logic [31:0] rdat;
} table_row_t;

localparam int TABLE_ROWS = 19;

localparam table_row_t TEST_TABLE [TABLE_ROWS] = '{
	// Reset values, PB count first so no port B transfer precedes it
	'{PORT_B, 1'b0, PB_CNT_ADR, 32'h0000_0000, 32'h0000_0000},
	'{PORT_A, 1'b0, PA_CNT_ADR, 32'h0000_0000, 32'h0000_0000},
	'{PORT_B, 1'b0, LED_ADR, 32'h0000_0000, 32'h0000_0000},
	// LED keeps the low 10 bits only
	'{PORT_B, 1'b1, LED_ADR, 32'hFFFF_FABC, 32'h0000_0000},
	'{PORT_B, 1'b0, LED_ADR, 32'h0000_0000, 32'h0000_02BC},
	'{PORT_B, 1'b1, CYC_ADR, 32'h1234_5678, 32'h0000_0000},
	'{PORT_B, 1'b0, LED_ADR, 32'h0000_0000, 32'h0000_02BC},
	// Unmapped space
	'{PORT_B, 1'b1, 32'h2000_0000, 32'hDEAD_BEEF, 32'h0000_0000},
	'{PORT_B, 1'b0, 32'h2000_0000, 32'h0000_0000, 32'h0000_0000},
	'{PORT_A, 1'b0, 32'h5000_0010, 32'h0000_0000, 32'h0000_0000},
	// RAM edges, an overwrite and a write just past the window
	'{PORT_B, 1'b1, 32'h0001_0000, 32'hA5A5_0001, 32'h0000_0000},
	'{PORT_B, 1'b1, 32'h0001_0FFC, 32'h0BAD_CAFE, 32'h0000_0000},
	'{PORT_B, 1'b1, 32'h0001_0000, 32'h1357_9BDF, 32'h0000_0000},
	'{PORT_B, 1'b1, 32'h0001_1000, 32'hFFFF_0000, 32'h0000_0000},
	'{PORT_A, 1'b0, 32'h0001_0000, 32'h0000_0000, 32'h1357_9BDF},
	'{PORT_B, 1'b0, 32'h0001_0FFC, 32'h0000_0000, 32'h0BAD_CAFE},
	'{PORT_B, 1'b0, 32'h0001_1000, 32'h0000_0000, 32'h0000_0000},
	'{PORT_B, 1'b1, LED_ADR, 32'h0000_0155, 32'h0000_0000},
	'{PORT_B, 1'b0, LED_ADR, 32'h0000_0000, 32'h0000_0155}
};

`endif

//--- verif/tb_soc_core.sv
`timescale 1ns/10ps

module tb_soc_core;
	import soc_pkg::*;

	`include "soc_tb_table.svh"

	localparam int TIMEOUT_CYCLES = TABLE_ROWS * 8 + 400;
	localparam int RAND_WORDS = 8;

	logic              clock;
	logic              i_rst;
	logic              pa_cyc;
	logic              pa_stb;
	logic [ADDR_W-1:0] pa_adr;
	logic [DATA_W-1:0] pa_dat;
	logic              pa_ack;
	logic              pb_cyc;
	logic              pb_stb;
	logic              pb_we;
	logic [ADDR_W-1:0] pb_adr;
	logic [DATA_W-1:0] pb_dat_w;
	logic [DATA_W-1:0] pb_dat;
	logic              pb_ack;
	logic [LED_W-1:0]  ledr;

	// Reference state
	logic [31:0]      ram_model [RAM_WORDS];
	logic [LED_W-1:0] led_model;
	logic [31:0]      rng;
	int               cycle_count;
	int               errors;
	int               tests;
	int               failed_tests;
	int               pa_acks;
	int               pb_acks;
	logic             ack_order [$];

	soc_core u_soc_core (
		.clock(clock), .i_rst(i_rst),
		.i_pa_cyc(pa_cyc), .i_pa_stb(pa_stb), .i_pa_adr(pa_adr),
		.o_pa_dat(pa_dat), .o_pa_ack(pa_ack),
		.i_pb_cyc(pb_cyc), .i_pb_stb(pb_stb), .i_pb_we(pb_we),
		.i_pb_adr(pb_adr), .i_pb_dat(pb_dat_w),
		.o_pb_dat(pb_dat), .o_pb_ack(pb_ack),
		.o_ledr(ledr)
	);

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge clock);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	// Acks are stable at the falling edge
	always @(negedge clock)
	begin
		if (!i_rst && (pa_ack || pb_ack))
		begin
			ack_order.push_back(pb_ack);
			if (pa_ack)
				pa_acks++;
			else
				pb_acks++;
		end
	end

	// ======================================================================
	// Helpers
	// ======================================================================
	function automatic logic [31:0] xorshift_next(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic int word_of(input logic [31:0] adr);
		return int'((adr - RAM_BASE) >> 2);
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("ERR %0t: %s read %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int err_mark);
		tests++;
		if (errors != err_mark)
			failed_tests++;
		$display("%s %s", (errors == err_mark) ? "ok    " : "FAILED", name);
	endtask

	// ======================================================================
	// Wishbone port drivers
	// ======================================================================
	task automatic port_a_read(input logic [31:0] adr, output logic [31:0] dat);
		pa_cyc = 1'b1;
		pa_stb = 1'b1;
		pa_adr = adr;
		@(negedge clock);
		while (!pa_ack)
			@(negedge clock);
		dat = pa_dat;
		@(negedge clock);
		pa_cyc = 1'b0;
		pa_stb = 1'b0;
	endtask

	task automatic port_b_read(input logic [31:0] adr, output logic [31:0] dat);
		pb_cyc = 1'b1;
		pb_stb = 1'b1;
		pb_we = 1'b0;
		pb_adr = adr;
		@(negedge clock);
		while (!pb_ack)
			@(negedge clock);
		dat = pb_dat;
		@(negedge clock);
		pb_cyc = 1'b0;
		pb_stb = 1'b0;
	endtask

	task automatic port_b_write(input logic [31:0] adr, input logic [31:0] dat);
		pb_cyc = 1'b1;
		pb_stb = 1'b1;
		pb_we = 1'b1;
		pb_adr = adr;
		pb_dat_w = dat;
		@(negedge clock);
		while (!pb_ack)
			@(negedge clock);
		@(negedge clock);
		pb_cyc = 1'b0;
		pb_stb = 1'b0;
		pb_we = 1'b0;
		// Model follows the address map
		if (adr >= RAM_BASE && adr < RAM_BASE + RAM_WORDS * 4)
			ram_model[word_of(adr)] = dat;
		else if (adr == LED_ADR)
			led_model = dat[LED_W-1:0];
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================
	initial
	begin
		table_row_t  row;
		logic [31:0] got;
		logic [31:0] got_a;
		logic [31:0] got_b;
		logic [31:0] first;
		logic [31:0] rand_adr [RAND_WORDS];
		int          expect_cnt;
		int          err_mark;

		i_rst = 1'b1;
		pa_cyc = 1'b0;
		pa_stb = 1'b0;
		pa_adr = '0;
		pb_cyc = 1'b0;
		pb_stb = 1'b0;
		pb_we = 1'b0;
		pb_adr = '0;
		pb_dat_w = '0;
		led_model = '0;
		rng = 32'h4712_7619;
		errors = 0;
		tests = 0;
		failed_tests = 0;
		pa_acks = 0;
		pb_acks = 0;
		repeat (8) @(negedge clock);
		i_rst = 1'b0;

		err_mark = errors;
		check_value("o_ledr after reset", 32'(ledr), 32'h0);
		end_test("LED output after reset", err_mark);

		for (int i = 0; i < TABLE_ROWS; i++)
		begin
			err_mark = errors;
			row = TEST_TABLE[i];
			if (row.is_write)
				port_b_write(row.adr, row.wdat);
			else if (row.port == PORT_B)
				port_b_read(row.adr, got);
			else
				port_a_read(row.adr, got);
			if (!row.is_write)
				check_value($sformatf("address %h", row.adr), got, row.rdat);
			check_value("o_ledr", 32'(ledr), 32'(led_model));
			end_test($sformatf("table row %0d", i), err_mark);
		end

		// Random words read back through both ports
		err_mark = errors;
		for (int k = 0; k < RAND_WORDS; k++)
		begin
			rng = xorshift_next(rng);
			rand_adr[k] = RAM_BASE + 32'((rng % RAM_WORDS) * 4);
			rng = xorshift_next(rng);
			port_b_write(rand_adr[k], rng);
		end
		for (int k = 0; k < RAND_WORDS; k++)
		begin
			port_b_read(rand_adr[k], got);
			check_value("RAM through port B", got, ram_model[word_of(rand_adr[k])]);
			port_a_read(rand_adr[k], got);
			check_value("RAM through port A", got, ram_model[word_of(rand_adr[k])]);
		end
		end_test("RAM random write and readback", err_mark);

		// Both ports request together and keep requesting
		err_mark = errors;
		ack_order.delete();
		fork
			for (int k = 0; k < 4; k++)
			begin
				port_a_read(rand_adr[k], got_a);
				check_value("contended port A", got_a, ram_model[word_of(rand_adr[k])]);
			end
			for (int k = 0; k < 4; k++)
			begin
				port_b_read(rand_adr[k + 4], got_b);
				check_value("contended port B", got_b, ram_model[word_of(rand_adr[k + 4])]);
			end
		join
		assert (ack_order.size() == 8)
		else
		begin
			$display("Expected 8 acks under contention but saw %0d", ack_order.size());
			errors++;
		end
		for (int k = 1; k < ack_order.size(); k++)
		begin
			assert (ack_order[k] != ack_order[k - 1])
			else
			begin
				$display("ERR %0t: acks %0d and %0d went to the same port", $time, k - 1, k);
				errors++;
			end
		end
		end_test("round-robin contention", err_mark);

		// A count read sees only transfers finished before it
		err_mark = errors;
		expect_cnt = pa_acks;
		port_b_read(PA_CNT_ADR, got);
		check_value("REG_PA_COUNT through port B", got, 32'(expect_cnt));
		expect_cnt = pb_acks;
		port_b_read(PB_CNT_ADR, got);
		check_value("REG_PB_COUNT through port B", got, 32'(expect_cnt));
		expect_cnt = pa_acks;
		port_a_read(PA_CNT_ADR, got);
		check_value("REG_PA_COUNT through port A", got, 32'(expect_cnt));
		end_test("transfer counters", err_mark);

		err_mark = errors;
		port_b_read(CYC_ADR, first);
		port_b_read(CYC_ADR, got);
		// Never ahead of the clock cycles seen so far, so the earlier write did not load it
		assert (first < 32'(cycle_count))
		else
		begin
			$display("ERR %0t: REG_CYCLES read %h after only %0d cycles",
				$time, first, cycle_count);
			errors++;
		end
		assert (got > first)
		else
		begin
			$display("ERR %0t: REG_CYCLES went from %h to %h", $time, first, got);
			errors++;
		end
		end_test("cycle counter advances", err_mark);

		$display("Tests: %0d run, %0d failed, %0d check errors", tests, failed_tests, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- src.f
+incdir+include
design/soc_pkg.sv
design/bus_access.sv
design/ram_block.sv
design/periph_block.sv
design/bus_fabric.sv
design/soc_core.sv
verif/tb_soc_core.sv

//--- Bender.yml
package:
  name: soc_core

sources:
  - files:
      - design/soc_pkg.sv
      - design/bus_access.sv
      - design/ram_block.sv
      - design/periph_block.sv
      - design/bus_fabric.sv
      - design/soc_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_soc_core.sv
